// ==== build.f ====
+incdir+source
+incdir+verif
source/mini_core_pkg.sv
source/mini_core_byp_if.sv
source/mini_core_regfile.sv
source/mini_core_id_stage.sv
source/mini_core_controller_bypass.sv
source/mini_core_ex_stage.sv
source/mini_core_wb_stage.sv
source/mini_core_top.sv
verif/mini_core_tb.sv

// ==== verif/mini_core_model.svh ====
// Mini core reference model with register and RAM state and a random instruction source
`ifndef MINI_CORE_MODEL_SVH
`define MINI_CORE_MODEL_SVH

// One sample of the retire port
typedef struct packed {
  logic                   valid;
  logic                   we;
  logic [`MC_RADDR_W-1:0] waddr;
  logic [`MC_XLEN-1:0]    wdata;
} retire_t;

// Architectural state of the model
logic [`MC_XLEN-1:0] model_regs [`MC_NUM_REGS];
logic [`MC_XLEN-1:0] model_ram  [`MC_RAM_WORDS];

// Registers and RAM start at zero like the DUT after reset
task automatic clear_state();
  for (int i = 0; i < `MC_NUM_REGS; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < `MC_RAM_WORDS; i++) begin
    model_ram[i] = '0;
  end
endtask

// Mostly r0..r4 so that neighbours collide often
function automatic logic [`MC_RADDR_W-1:0] pick_reg();
  int unsigned r;
  if (($urandom % 4) != 0) begin
    r = $urandom % 5;
  end else begin
    r = $urandom % `MC_NUM_REGS;
  end
  return r[`MC_RADDR_W-1:0];
endfunction

// Random word weighted toward loads so load-use cases are frequent
function automatic logic [31:0] random_instr();
  int unsigned sel;
  int unsigned rnd;
  logic [3:0]  op;
  logic [15:0] low;
  sel = $urandom % 14;
  case (sel)
    0, 1, 13: op = OP_ADD;
    2:        op = OP_SUB;
    3:        op = OP_XOR;
    4, 5:     op = OP_ADDI;
    6, 7, 8:  op = OP_LD;
    9, 10:    op = OP_ST;
    11:       op = OP_NOP;
    default: begin
      // Undefined codes 7..15
      rnd = 7 + ($urandom % 9);
      op  = rnd[3:0];
    end
  endcase
  // Small offsets half the time so stores and loads meet on one address
  rnd = $urandom;
  if (($urandom % 2) != 0) begin
    low = {14'd0, rnd[1:0]};
  end else begin
    low = rnd[15:0];
  end
  return {op, pick_reg(), pick_reg(), pick_reg(), low};
endfunction

// Execute one instruction in program order and build its retire entry
task automatic execute_instr(input logic [31:0] w, output retire_t entry);
  logic [3:0]          op;
  logic [3:0]          rd;
  logic [3:0]          rs1;
  logic [3:0]          rs2;
  logic [`MC_XLEN-1:0] a;
  logic [`MC_XLEN-1:0] imm;
  logic [`MC_XLEN-1:0] addr;
  logic [`MC_XLEN-1:0] res;
  logic                wr;
  op   = w[31:28];
  rd   = w[27:24];
  rs1  = w[23:20];
  rs2  = w[19:16];
  a    = model_regs[rs1];
  imm  = {{(`MC_XLEN-16){w[15]}}, w[15:0]};
  addr = a + imm;
  res  = '0;
  wr   = 1'b1;
  case (op)
    OP_ADD:  res = a + model_regs[rs2];
    OP_SUB:  res = a - model_regs[rs2];
    OP_XOR:  res = a ^ model_regs[rs2];
    OP_ADDI: res = a + imm;
    OP_LD:   res = model_ram[addr % `MC_RAM_WORDS];
    // Store data register sits in the rd field
    OP_ST: begin
      model_ram[addr % `MC_RAM_WORDS] = model_regs[rd];
      wr = 1'b0;
    end
    default: wr = 1'b0;
  endcase
  // r0 stays zero and retires without a write
  if (wr && (rd != 4'd0)) begin
    model_regs[rd] = res;
    entry = {1'b1, 1'b1, rd, res};
  end else begin
    entry = {1'b1, 1'b0, {`MC_RADDR_W{1'b0}}, {`MC_XLEN{1'b0}}};
  end
endtask

`endif

// ==== verif/mini_core_tb.sv ====
// Mini core testbench driving a random instruction stream and checking ready and retire per cycle
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_tb;
  import mini_core_pkg::*;

  localparam int unsigned NUM_INSTR      = 400;
  localparam int unsigned TIMEOUT_CYCLES = NUM_INSTR * 4 + 50;
  localparam int unsigned RAND_SEED      = 33258;
  localparam int unsigned RESET_CYCLES   = 5;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   instr_valid;
  logic [`MC_XLEN-1:0]    instr;
  logic                   instr_ready;
  logic                   retire_valid;
  logic                   retire_we;
  logic [`MC_RADDR_W-1:0] retire_waddr;
  logic [`MC_XLEN-1:0]    retire_wdata;
  int unsigned            cycle_cnt = 0;

  `include "mini_core_model.svh"

  // Expected retire entries in program order
  retire_t exp_q [$];

  mini_core_top DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .instr_ready_o  (instr_ready),
    .retire_valid_o (retire_valid),
    .retire_we_o    (retire_we),
    .retire_waddr_o (retire_waddr),
    .retire_wdata_o (retire_wdata)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Error %s: expected instr_ready=%0b actual instr_ready=%0b",
                          name, exp, act));
    end
  endtask

  task automatic check_retire(input string name, input retire_t exp, input retire_t act);
    string exp_txt;
    string act_txt;
    if (act !== exp) begin
      exp_txt = $sformatf("valid=%0b we=%0b waddr=%0d wdata=%h",
                          exp.valid, exp.we, exp.waddr, exp.wdata);
      act_txt = $sformatf("valid=%0b we=%0b waddr=%0d wdata=%h",
                          act.valid, act.we, act.waddr, act.wdata);
      abort_run($sformatf("Error %s: expected %s actual %s", name, exp_txt, act_txt));
    end
  endtask

  // Nonzero register r read on an enabled port of word w
  function automatic logic reads_reg(input logic [31:0] w, input logic [3:0] r);
    if (r == 4'd0) begin
      return 1'b0;
    end
    case (w[31:28])
      OP_ADD, OP_SUB, OP_XOR: return (w[23:20] == r) || (w[19:16] == r);
      OP_ADDI, OP_LD:         return w[23:20] == r;
      OP_ST:                  return (w[23:20] == r) || (w[27:24] == r);
      default:                return 1'b0;
    endcase
  endfunction

  // Whole run bounded by cycle count
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        abort_run("Timed out before all instructions retired");
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus and shadow pipeline
  ////////////////////////////////////////

  initial begin
    logic        id_v;
    logic        ex_v;
    logic        wb_v;
    logic [31:0] id_w;
    logic [31:0] ex_w;
    logic [31:0] pending;
    logic        stall;
    logic        accepted;
    int unsigned n_acc;
    int unsigned n_ret;
    retire_t     exp_entry;
    retire_t     act_entry;
    retire_t     new_entry;

    void'($urandom(RAND_SEED));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    clear_state();
    id_v    = 1'b0;
    ex_v    = 1'b0;
    wb_v    = 1'b0;
    id_w    = '0;
    ex_w    = '0;
    n_acc   = 0;
    n_ret   = 0;
    pending = random_instr();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Sample mid-cycle and drive for the next rising edge
    while ((n_acc < NUM_INSTR) || id_v || ex_v || wb_v) begin
      @(negedge clk);

      // Load in EX whose rd is read by the valid instruction in ID
      stall = id_v && ex_v && (ex_w[31:28] == OP_LD) && (ex_w[27:24] != 4'd0) &&
              reads_reg(id_w, ex_w[27:24]);
      check_ready($sformatf("ready after %0d accepted", n_acc), !stall, instr_ready);

      // Retire valid only when the shadow WB slot holds an instruction
      if (wb_v) begin
        exp_entry = exp_q.pop_front();
        n_ret++;
      end else begin
        exp_entry = '0;
      end
      act_entry = {retire_valid, retire_we, retire_waddr, retire_wdata};
      check_retire($sformatf("retire %0d", n_ret), exp_entry, act_entry);

      // About one cycle in five idle with garbage on the bus
      accepted = 1'b0;
      if ((n_acc < NUM_INSTR) && (($urandom % 5) != 0)) begin
        instr_valid = 1'b1;
        instr       = pending;
        accepted    = !stall;
      end else begin
        instr_valid = 1'b0;
        instr       = $urandom;
      end

      if (accepted) begin
        execute_instr(pending, new_entry);
        exp_q.push_back(new_entry);
        n_acc++;
      end

      // Advance to the state after the coming rising edge
      wb_v = ex_v;
      if (stall) begin
        // ID holds while EX gets a bubble
        ex_v = 1'b0;
      end else begin
        ex_v = id_v;
        ex_w = id_w;
        id_v = accepted;
        id_w = pending;
      end
      if (accepted) begin
        pending = random_instr();
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule
`default_nettype wire

// ==== source/mini_core_top.sv ====
// Mini core top level joining the ID, EX and WB stages with the bypass controller
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  logic [`MC_XLEN-1:0]    instr_i,
  output logic                   instr_ready_o,
  output logic                   retire_valid_o,
  output logic                   retire_we_o,
  output logic [`MC_RADDR_W-1:0] retire_waddr_o,
  output logic [`MC_XLEN-1:0]    retire_wdata_o
);
  import mini_core_pkg::*;

  id_ex_pipe_t            id_ex_pipe;
  ex_wb_pipe_t            ex_wb_pipe;
  logic [`MC_XLEN-1:0]    ex_result;
  logic                   wb_we;
  logic [`MC_RADDR_W-1:0] wb_waddr;
  logic [`MC_XLEN-1:0]    wb_wdata;

  // ID to controller bundle
  mini_core_byp_if byp_if ();

  mini_core_id_stage u_id_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .byp           (byp_if.id),
    .ex_result_i   (ex_result),
    .wb_result_i   (wb_wdata),
    .wb_we_i       (wb_we),
    .wb_waddr_i    (wb_waddr),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  mini_core_controller_bypass u_controller_bypass (
    .byp          (byp_if.ctrl),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_wb_pipe_i (ex_wb_pipe)
  );

  mini_core_ex_stage u_ex_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_result_o  (ex_result),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  mini_core_wb_stage u_wb_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ex_wb_pipe_i   (ex_wb_pipe),
    .wb_we_o        (wb_we),
    .wb_waddr_o     (wb_waddr),
    .wb_wdata_o     (wb_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_we_o    (retire_we_o),
    .retire_waddr_o (retire_waddr_o),
    .retire_wdata_o (retire_wdata_o)
  );

endmodule
`default_nettype wire

// ==== source/mini_core_wb_stage.sv ====
// WB stage with data RAM access, write-back value selection and the retire port
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_wb_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  mini_core_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  output logic                       wb_we_o,
  output logic [`MC_RADDR_W-1:0]     wb_waddr_o,
  output logic [`MC_XLEN-1:0]        wb_wdata_o,
  output logic                       retire_valid_o,
  output logic                       retire_we_o,
  output logic [`MC_RADDR_W-1:0]     retire_waddr_o,
  output logic [`MC_XLEN-1:0]        retire_wdata_o
);

  localparam int unsigned RAM_AW = $clog2(`MC_RAM_WORDS);

  logic [`MC_XLEN-1:0] ram_q [`MC_RAM_WORDS];
  logic [RAM_AW-1:0]   ram_addr;
  logic                is_load;
  logic                is_store;

  // Low address bits index the RAM
  assign ram_addr = ex_wb_pipe_i.result[RAM_AW-1:0];
  assign is_load  = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en && !ex_wb_pipe_i.lsu_we;
  assign is_store = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en && ex_wb_pipe_i.lsu_we;

  // Store lands at end of WB, visible to a load right behind it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MC_RAM_WORDS; i++) begin
        ram_q[i] <= '0;
      end
    end else if (is_store) begin
      ram_q[ram_addr] <= ex_wb_pipe_i.store_data;
    end
  end

  ////////////////////////////////////////
  // Write-back and retire
  ////////////////////////////////////////

  // Async RAM read for loads, ALU result otherwise
  assign wb_wdata_o = is_load ? ram_q[ram_addr] : ex_wb_pipe_i.result;
  assign wb_we_o    = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.rf_we;
  assign wb_waddr_o = ex_wb_pipe_i.rf_waddr;

  // One retire per valid WB instruction
  assign retire_valid_o = ex_wb_pipe_i.instr_valid;
  assign retire_we_o    = wb_we_o;
  // Address and data read as zero when nothing is written
  assign retire_waddr_o = wb_we_o ? wb_waddr_o : '0;
  assign retire_wdata_o = wb_we_o ? wb_wdata_o : '0;

endmodule
`default_nettype wire

// ==== source/mini_core_ex_stage.sv ====
// EX stage with ALU, load/store address adder and the EX/WB pipe register
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_ex_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  mini_core_pkg::id_ex_pipe_t id_ex_pipe_i,
  output logic [`MC_XLEN-1:0]        ex_result_o,
  output mini_core_pkg::ex_wb_pipe_t ex_wb_pipe_o
);
  import mini_core_pkg::*;

  logic [`MC_XLEN-1:0] imm_sext;
  logic [`MC_XLEN-1:0] lsu_addr;
  ex_wb_pipe_t         ex_wb_d;

  // Address is base register plus signed offset
  assign imm_sext = {{(`MC_XLEN-16){id_ex_pipe_i.imm[15]}}, id_ex_pipe_i.imm};
  assign lsu_addr = id_ex_pipe_i.operand_a + imm_sext;

  // ALU, also feeds EX forwarding into ID
  always_comb begin
    case (id_ex_pipe_i.op)
      OP_ADD, OP_ADDI: ex_result_o = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
      OP_SUB:          ex_result_o = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      OP_XOR:          ex_result_o = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      OP_LD, OP_ST:    ex_result_o = lsu_addr;
      default:         ex_result_o = '0;
    endcase
  end

  always_comb begin
    ex_wb_d.instr_valid = id_ex_pipe_i.instr_valid;
    ex_wb_d.rf_we       = id_ex_pipe_i.rf_we;
    ex_wb_d.rf_waddr    = id_ex_pipe_i.rf_waddr;
    ex_wb_d.lsu_en      = id_ex_pipe_i.lsu_en;
    ex_wb_d.lsu_we      = id_ex_pipe_i.lsu_en && (id_ex_pipe_i.op == OP_ST);
    ex_wb_d.result      = ex_result_o;
    ex_wb_d.store_data  = id_ex_pipe_i.store_data;
  end

  // WB never back-pressures, so EX always advances
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb_pipe_o <= '0;
    end else begin
      ex_wb_pipe_o <= ex_wb_d;
    end
  end

endmodule
`default_nettype wire

// ==== source/mini_core_controller_bypass.sv ====
// Bypass controller producing operand forwarding selects and the load-use stall
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_controller_bypass (
  mini_core_byp_if.ctrl              byp,
  input  mini_core_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  mini_core_pkg::ex_wb_pipe_t ex_wb_pipe_i
);
  import mini_core_pkg::*;

  logic [`MC_NUM_RD_PORTS-1:0] rf_rd_ex_match;
  logic [`MC_NUM_RD_PORTS-1:0] rf_rd_wb_match;
  logic                        rf_we_ex;
  logic                        rf_we_wb;
  logic                        load_in_ex;

  // Writers qualified by their stage valid
  assign rf_we_ex   = id_ex_pipe_i.rf_we && id_ex_pipe_i.instr_valid;
  assign rf_we_wb   = ex_wb_pipe_i.rf_we && ex_wb_pipe_i.instr_valid;
  // Only loads write rd among LSU ops
  assign load_in_ex = id_ex_pipe_i.lsu_en && rf_we_ex;

  // Per port address match, r0 excluded
  for (genvar g = 0; g < `MC_NUM_RD_PORTS; g++) begin : gen_match
    assign rf_rd_ex_match[g] = rf_we_ex && byp.rf_re[g] && (|byp.rf_raddr[g]) &&
                               (id_ex_pipe_i.rf_waddr == byp.rf_raddr[g]);
    assign rf_rd_wb_match[g] = rf_we_wb && byp.rf_re[g] && (|byp.rf_raddr[g]) &&
                               (ex_wb_pipe_i.rf_waddr == byp.rf_raddr[g]);
  end

  ////////////////////////////////////////
  // Stall
  ////////////////////////////////////////

  // Load data is not ready in EX, hold ID one cycle
  // Next cycle the load sits in WB and forwards from there
  assign byp.load_stall = byp.valid_id && load_in_ex && (|rf_rd_ex_match);

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////

  always_comb begin
    byp.op_a_sel = SEL_REGFILE;
    byp.op_b_sel = SEL_REGFILE;

    // WB first
    if (rf_rd_wb_match[0]) begin
      byp.op_a_sel = SEL_FW_WB;
    end
    if (rf_rd_wb_match[1]) begin
      byp.op_b_sel = SEL_FW_WB;
    end

    // EX holds the newer value and wins
    if (rf_rd_ex_match[0]) begin
      byp.op_a_sel = SEL_FW_EX;
    end
    if (rf_rd_ex_match[1]) begin
      byp.op_b_sel = SEL_FW_EX;
    end
  end

endmodule
`default_nettype wire

// ==== source/mini_core_id_stage.sv ====
// ID stage with IF/ID register, decode, register read and operand forwarding muxes
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_id_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       instr_valid_i,
  input  logic [`MC_XLEN-1:0]        instr_i,
  output logic                       instr_ready_o,
  mini_core_byp_if.id                byp,
  input  logic [`MC_XLEN-1:0]        ex_result_i,
  input  logic [`MC_XLEN-1:0]        wb_result_i,
  input  logic                       wb_we_i,
  input  logic [`MC_RADDR_W-1:0]     wb_waddr_i,
  output mini_core_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import mini_core_pkg::*;

  logic                        if_id_valid_q;
  instr_u                      if_id_instr_q;
  opcode_e                     op_id;
  logic [`MC_NUM_RD_PORTS-1:0] rf_re_id;
  logic                        writes_rd;
  logic                        lsu_en_id;
  logic                        is_st;
  logic                        use_imm;
  logic [`MC_XLEN-1:0]         imm_sext;
  logic [`MC_XLEN-1:0]         rf_rdata [`MC_NUM_RD_PORTS];
  logic [`MC_XLEN-1:0]         port1_data;
  id_ex_pipe_t                 id_ex_d;

  // Pick operand source, EX and WB values bypass the register file
  function automatic logic [`MC_XLEN-1:0] fw_mux(input fw_sel_e             sel,
                                                 input logic [`MC_XLEN-1:0] rf_val,
                                                 input logic [`MC_XLEN-1:0] ex_val,
                                                 input logic [`MC_XLEN-1:0] wb_val);
    case (sel)
      SEL_FW_EX: return ex_val;
      SEL_FW_WB: return wb_val;
      default:   return rf_val;
    endcase
  endfunction

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  // No acceptance while stalled
  assign instr_ready_o = !byp.load_stall;

  // Dropped valid leaves a bubble in ID
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_valid_q <= 1'b0;
    end else if (!byp.load_stall) begin
      if_id_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!byp.load_stall && instr_valid_i) begin
      if_id_instr_q <= instr_i;
    end
  end

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign op_id    = if_id_instr_q.r_fmt.op;
  assign imm_sext = {{(`MC_XLEN-16){if_id_instr_q.i_fmt.imm[15]}}, if_id_instr_q.i_fmt.imm};

  always_comb begin
    rf_re_id  = 2'b00;
    writes_rd = 1'b0;
    lsu_en_id = 1'b0;
    is_st     = 1'b0;
    use_imm   = 1'b0;
    case (op_id)
      OP_ADD, OP_SUB, OP_XOR: begin
        rf_re_id  = 2'b11;
        writes_rd = 1'b1;
      end
      OP_ADDI: begin
        rf_re_id  = 2'b01;
        writes_rd = 1'b1;
        use_imm   = 1'b1;
      end
      OP_LD: begin
        rf_re_id  = 2'b01;
        writes_rd = 1'b1;
        lsu_en_id = 1'b1;
        use_imm   = 1'b1;
      end
      // Store data comes from the rd field on port 1
      OP_ST: begin
        rf_re_id  = 2'b11;
        lsu_en_id = 1'b1;
        is_st     = 1'b1;
        use_imm   = 1'b1;
      end
      default: ;
    endcase
  end

  // Read request to the controller
  assign byp.rf_re       = rf_re_id;
  assign byp.rf_raddr[0] = if_id_instr_q.r_fmt.rs1;
  assign byp.rf_raddr[1] = is_st ? if_id_instr_q.r_fmt.rd : if_id_instr_q.r_fmt.rs2;
  assign byp.valid_id    = if_id_valid_q;

  mini_core_regfile u_regfile (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .raddr_i (byp.rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (wb_we_i),
    .waddr_i (wb_waddr_i),
    .wdata_i (wb_result_i)
  );

  ////////////////////////////////////////
  // Operands and ID/EX register
  ////////////////////////////////////////

  assign port1_data = fw_mux(byp.op_b_sel, rf_rdata[1], ex_result_i, wb_result_i);

  always_comb begin
    id_ex_d.instr_valid = if_id_valid_q;
    id_ex_d.op          = op_id;
    // rd of zero never claims a write
    id_ex_d.rf_we       = writes_rd && (if_id_instr_q.r_fmt.rd != '0);
    id_ex_d.rf_waddr    = if_id_instr_q.r_fmt.rd;
    id_ex_d.lsu_en      = lsu_en_id;
    id_ex_d.operand_a   = fw_mux(byp.op_a_sel, rf_rdata[0], ex_result_i, wb_result_i);
    id_ex_d.operand_b   = use_imm ? imm_sext : port1_data;
    id_ex_d.store_data  = port1_data;
    id_ex_d.imm         = if_id_instr_q.i_fmt.imm;
  end

  // Stall pushes a bubble into EX
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_pipe_o <= '0;
    end else if (byp.load_stall) begin
      id_ex_pipe_o <= '0;
    end else begin
      id_ex_pipe_o <= id_ex_d;
    end
  end

endmodule
`default_nettype wire

// ==== source/mini_core_regfile.sv ====
// Flip-flop register file with two read ports, one write port and a hardwired zero register
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

module mini_core_regfile (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [`MC_RADDR_W-1:0]       raddr_i [`MC_NUM_RD_PORTS],
  output logic [`MC_XLEN-1:0]          rdata_o [`MC_NUM_RD_PORTS],
  input  logic                         we_i,
  input  logic [`MC_RADDR_W-1:0]       waddr_i,
  input  logic [`MC_XLEN-1:0]          wdata_i
);

  logic [`MC_XLEN-1:0] regs_q [`MC_NUM_REGS];

  // Write at end of WB cycle, r0 is never written
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MC_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Async read, r0 forced to zero
  for (genvar g = 0; g < `MC_NUM_RD_PORTS; g++) begin : gen_rd_port
    assign rdata_o[g] = (raddr_i[g] == '0) ? '0 : regs_q[raddr_i[g]];
  end

endmodule
`default_nettype wire

// ==== source/mini_core_byp_if.sv ====
// Read port and forwarding select bundle between the ID stage and the bypass controller
`timescale 1ns/1ns
`default_nettype none
`include "mini_core_defines.svh"

interface mini_core_byp_if;
  import mini_core_pkg::*;

  // Driven by ID
  logic [`MC_NUM_RD_PORTS-1:0] rf_re;
  logic [`MC_RADDR_W-1:0]      rf_raddr [`MC_NUM_RD_PORTS];
  logic                        valid_id;

  // Driven by the controller
  fw_sel_e                     op_a_sel;
  fw_sel_e                     op_b_sel;
  logic                        load_stall;

  modport id   (output rf_re, rf_raddr, valid_id, input op_a_sel, op_b_sel, load_stall);
  modport ctrl (input rf_re, rf_raddr, valid_id, output op_a_sel, op_b_sel, load_stall);

endinterface
`default_nettype wire

// ==== source/mini_core_pkg.sv ====
// Mini core package with the opcode, instruction format and pipe register types
`default_nettype none
`include "mini_core_defines.svh"

package mini_core_pkg;

  // Opcodes in the top nibble, undefined codes behave as NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_XOR  = 4'd3,
    OP_ADDI = 4'd4,
    OP_LD   = 4'd5,
    OP_ST   = 4'd6
  } opcode_e;

  // Register format
  typedef struct packed {
    opcode_e                op;
    logic [`MC_RADDR_W-1:0] rd;
    logic [`MC_RADDR_W-1:0] rs1;
    logic [`MC_RADDR_W-1:0] rs2;
    logic [15:0]            unused;
  } r_fmt_t;

  // Immediate format, imm sits in the low half
  typedef struct packed {
    opcode_e                op;
    logic [`MC_RADDR_W-1:0] rd;
    logic [`MC_RADDR_W-1:0] rs1;
    logic [3:0]             rsvd;
    logic [15:0]            imm;
  } i_fmt_t;

  // Same word seen through both formats
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  // Operand source select
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // ID to EX pipe
  typedef struct packed {
    logic                   instr_valid;
    opcode_e                op;
    logic                   rf_we;
    logic [`MC_RADDR_W-1:0] rf_waddr;
    logic                   lsu_en;
    logic [`MC_XLEN-1:0]    operand_a;
    logic [`MC_XLEN-1:0]    operand_b;
    logic [`MC_XLEN-1:0]    store_data;
    logic [15:0]            imm;
  } id_ex_pipe_t;

  // EX to WB pipe, result holds ALU value or RAM address
  typedef struct packed {
    logic                   instr_valid;
    logic                   rf_we;
    logic [`MC_RADDR_W-1:0] rf_waddr;
    logic                   lsu_en;
    logic                   lsu_we;
    logic [`MC_XLEN-1:0]    result;
    logic [`MC_XLEN-1:0]    store_data;
  } ex_wb_pipe_t;

endpackage
`default_nettype wire

// ==== source/mini_core_defines.svh ====
// Mini core global sizes shared by the package, the interface and the RTL modules
`ifndef MINI_CORE_DEFINES_SVH
`define MINI_CORE_DEFINES_SVH

// Data path width
`define MC_XLEN 32

// Register file size and address width
`define MC_NUM_REGS 16
`define MC_RADDR_W 4

// Data RAM depth in words
`define MC_RAM_WORDS 16

// Register file read ports, A and B
`define MC_NUM_RD_PORTS 2

`endif
